//--- dv/tb_frontend.sv
module tb_frontend;
    timeunit 1ns;
    timeprecision 1ps;

    import fe_pkg::*;

    localparam int PROG_LEN  = 21;
    localparam int NUM_EXP   = 40;
    localparam int SEQ_XFERS = 20;
    // Generous bound on run length in clocks
    localparam int TIMEOUT   = 4 * NUM_EXP + PROG_LEN;

    logic               clk = 1'b0;
    logic               reset;
    logic               run;
    logic               load_en;
    logic [IMEM_AW-1:0] load_addr;
    logic [INST_WD-1:0] load_data;
    logic               out_allowin;
    logic               out_valid;
    logic [PC_WD-1:0]   out_pc;
    logic [INST_WD-1:0] out_inst;
    op_class_e          out_op;
    logic [PC_WD-1:0]   out_imm;

    // ------------------------------
    // Program image, word index = PC / 4
    // ------------------------------
    // Loop 36..80 keeps fetch inside loaded words
    logic [31:0] prog [PROG_LEN] = '{
        32'h0000_0013,  // 0: nop, never fetched
        32'h0050_0093,  // 4: addi x1, x0, 5
        32'h0100_A103,  // 8: lw x2, 16(x1)
        32'hFE20_AC23,  // 12: sw x2, -8(x1)
        32'hFE20_8AE3,  // 16: beq x1, x2, -12
        32'h0020_81B3,  // 20: add x3, x1, x2
        32'h1234_5237,  // 24: lui x4, 0x12345
        32'h0240_00EF,  // 28: jal x1, +36 to 64
        32'hABCD_E297,  // 32: auipc x5, delay slot
        32'h0000_0073,  // 36: ecall
        32'hFFF0_E313,  // 40: ori x6, x1, -1
        32'h0041_9AE3,  // 44: bne x3, x4, +2068
        32'h7E53_0FA3,  // 48: sb x5, 2047(x6)
        32'h0062_C3B3,  // 52: xor x7, x5, x6
        32'h8003_9403,  // 56: lh x8, -2048(x7)
        32'h0FF0_000F,  // 60: fence
        32'h00C0_8067,  // 64: jalr x0, 12(x1)
        32'hF9C1_2493,  // 68: slti x9, x2, -100
        32'h0034_C503,  // 72: lbu x10, 3(x9)
        32'hFD9F_F06F,  // 76: jal x0, -40 to 36
        32'h4075_5593   // 80: srai x11, x10, 7, delay slot
    };

    // Reference model state
    logic [31:0] model_pc;
    logic        jal_pending;
    logic [31:0] jal_target;

    // Expected values and held offer
    logic [31:0] exp_pc;
    logic [31:0] exp_inst;
    logic [31:0] exp_imm;
    op_class_e   exp_op;
    logic        hold_valid = 1'b0;
    logic [31:0] hold_pc;
    logic [31:0] hold_inst;
    logic [31:0] hold_imm;
    op_class_e   hold_op;

    // Bookkeeping
    int     errors = 0;
    int     xfer_count = 0;
    int     cycles = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    integer seed = 32'h3563;

    cpu_frontend UUT (
        .clk         (clk),
        .reset       (reset),
        .run         (run),
        .load_en     (load_en),
        .load_addr   (load_addr),
        .load_data   (load_data),
        .out_allowin (out_allowin),
        .out_valid   (out_valid),
        .out_pc      (out_pc),
        .out_inst    (out_inst),
        .out_op      (out_op),
        .out_imm     (out_imm)
    );

    always #50 clk = ~clk;

    // ------------------------------
    // Helpers
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("FAIL t=%0t %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    // Next instruction in program order, JAL redirect after one delay slot
    function automatic void ref_next(output logic [31:0] pc, output logic [31:0] inst,
                                     output op_class_e op, output logic [31:0] imm);
        int idx;
        pc   = model_pc;
        idx  = int'(model_pc[9:2]);
        inst = prog[idx];
        op   = OP_OTHER;
        imm  = 32'd0;
        case (inst[6:0])
            7'h13: begin
                op  = OP_ALU;
                imm = 32'($signed(inst[31:20]));
            end
            // R-type, no immediate
            7'h33: op = OP_ALU;
            7'h37, 7'h17: begin
                op  = OP_ALU;
                imm = {inst[31:12], 12'h000};
            end
            7'h03: begin
                op  = OP_LOAD;
                imm = 32'($signed(inst[31:20]));
            end
            7'h23: begin
                op  = OP_STORE;
                imm = 32'($signed({inst[31:25], inst[11:7]}));
            end
            7'h63: begin
                op  = OP_BRANCH;
                imm = 32'($signed({inst[31], inst[7], inst[30:25], inst[11:8], 1'b0}));
            end
            7'h6F: begin
                op  = OP_JAL;
                imm = 32'($signed({inst[31], inst[19:12], inst[20], inst[30:21], 1'b0}));
            end
            7'h67: begin
                op  = OP_JALR;
                imm = 32'($signed(inst[31:20]));
            end
            default: op = OP_OTHER;
        endcase
        // Pending redirect applies after the delay slot
        if (jal_pending) begin
            model_pc    = jal_target;
            jal_pending = 1'b0;
        end else begin
            model_pc = pc + 32'd4;
        end
        if (op == OP_JAL) begin
            jal_pending = 1'b1;
            jal_target  = pc + imm;
        end
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: failed, %0d errors", name, errors - errs_before);
        end
    endtask

    // ------------------------------
    // Compare process
    // ------------------------------
    // Negedge sampling, inputs settled at +5 ns
    always @(negedge clk) begin
        if (!reset) begin
            // Nothing leaves decode before run
            if (!run) begin
                check_value("out_valid", 32'(out_valid), 32'd0);
            end
            if (hold_valid) begin
                check_value("out_valid (held)", 32'(out_valid), 32'd1);
                check_value("out_pc (held)", out_pc, hold_pc);
                check_value("out_inst (held)", out_inst, hold_inst);
                check_value("out_op (held)", 32'(out_op), 32'(hold_op));
                check_value("out_imm (held)", out_imm, hold_imm);
            end
            if (out_valid && out_allowin) begin
                ref_next(exp_pc, exp_inst, exp_op, exp_imm);
                check_value("out_pc", out_pc, exp_pc);
                check_value("out_inst", out_inst, exp_inst);
                check_value("out_op", 32'(out_op), 32'(exp_op));
                check_value("out_imm", out_imm, exp_imm);
                xfer_count++;
            end
            hold_valid = out_valid && !out_allowin;
            hold_pc    = out_pc;
            hold_inst  = out_inst;
            hold_op    = out_op;
            hold_imm   = out_imm;
        end
    end

    // Run limit
    always @(posedge clk) begin
        cycles++;
        if (cycles > TIMEOUT) begin
            $display("timeout after %0d cycles, only %0d of %0d instructions seen",
                     cycles, xfer_count, NUM_EXP);
            $display("TEST FAILED");
            $finish;
        end
    end

    // ------------------------------
    // Stimulus
    // ------------------------------
    initial begin
        int          errs_before;
        logic [31:0] rnd;
        reset       = 1'b1;
        run         = 1'b0;
        load_en     = 1'b0;
        load_addr   = '0;
        load_data   = '0;
        out_allowin = 1'b0;
        model_pc    = RESET_PC + 32'd4;
        jal_pending = 1'b0;
        jal_target  = 32'd0;
        repeat (2) @(posedge clk);
        #5;
        reset = 1'b0;

        // Load with run low, decode must stay empty
        // Consumer ready, so a stray out_valid would count as a transfer
        errs_before = errors;
        out_allowin = 1'b1;
        for (int i = 0; i < PROG_LEN; i++) begin
            load_en   = 1'b1;
            load_addr = 8'(i);
            load_data = prog[i];
            next_cycle();
        end
        load_en = 1'b0;
        repeat (3) next_cycle();
        check_value("transfers while idle", 32'(xfer_count), 32'd0);
        report_test("idle_during_load", errs_before);

        // Full rate, covers both JALs and the backward jump
        errs_before = errors;
        out_allowin = 1'b1;
        run         = 1'b1;
        while (xfer_count < SEQ_XFERS) begin
            next_cycle();
        end
        report_test("in_order_with_jal", errs_before);

        // Random consumer stalls
        errs_before = errors;
        while (xfer_count < NUM_EXP) begin
            rnd         = $random(seed);
            out_allowin = rnd[0];
            next_cycle();
        end
        out_allowin = 1'b0;
        report_test("random_backpressure", errs_before);

        $display("summary: %0d tests ok, %0d failed, %0d transfers, %0d errors",
                 tests_passed, tests_failed, xfer_count, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

//--- hw/cpu_frontend.sv
module cpu_frontend (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       run,
    input  logic                       load_en,
    input  logic [fe_pkg::IMEM_AW-1:0] load_addr,
    input  logic [fe_pkg::INST_WD-1:0] load_data,
    input  logic                       out_allowin,
    output logic                       out_valid,
    output logic [fe_pkg::PC_WD-1:0]   out_pc,
    output logic [fe_pkg::INST_WD-1:0] out_inst,
    output fe_pkg::op_class_e          out_op,
    output logic [fe_pkg::PC_WD-1:0]   out_imm
);
    import fe_pkg::*;

    // ------------------------------
    // Internal nets
    // ------------------------------
    // Fetch to RAM
    logic               inst_en;
    logic [PC_WD-1:0]   inst_addr;
    logic [IMEM_AW-1:0] imem_rd_addr;
    logic [INST_WD-1:0] inst_rdata;

    // Fetch to decode
    logic               fs_to_ds_valid;
    logic [PC_WD-1:0]   fs_pc;
    logic               ds_allowin;

    // Decode back to fetch
    logic               br_taken;
    logic [PC_WD-1:0]   br_target;

    // Byte PC to word index, bits 9..2
    assign imem_rd_addr = inst_addr[IMEM_AW+1:2];

    fetch_stage u_fetch (
        .clk            (clk),
        .reset          (reset),
        .run            (run),
        .ds_allowin     (ds_allowin),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .inst_en        (inst_en),
        .inst_addr      (inst_addr),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc)
    );

    inst_mem u_imem (
        .clk        (clk),
        .inst_en    (inst_en),
        .rd_addr    (imem_rd_addr),
        .inst_rdata (inst_rdata),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data)
    );

    // RAM data arrives with fs_to_ds_valid, goes straight into decode
    decode_stage u_decode (
        .clk            (clk),
        .reset          (reset),
        .fs_to_ds_valid (fs_to_ds_valid),
        .fs_pc          (fs_pc),
        .fs_inst        (inst_rdata),
        .ds_allowin     (ds_allowin),
        .br_taken       (br_taken),
        .br_target      (br_target),
        .out_allowin    (out_allowin),
        .out_valid      (out_valid),
        .out_pc         (out_pc),
        .out_inst       (out_inst),
        .out_op         (out_op),
        .out_imm        (out_imm)
    );

endmodule

//--- hw/decode_stage.sv
module decode_stage (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       fs_to_ds_valid,
    input  logic [fe_pkg::PC_WD-1:0]   fs_pc,
    input  logic [fe_pkg::INST_WD-1:0] fs_inst,
    output logic                       ds_allowin,
    output logic                       br_taken,
    output logic [fe_pkg::PC_WD-1:0]   br_target,
    input  logic                       out_allowin,
    output logic                       out_valid,
    output logic [fe_pkg::PC_WD-1:0]   out_pc,
    output logic [fe_pkg::INST_WD-1:0] out_inst,
    output fe_pkg::op_class_e          out_op,
    output logic [fe_pkg::PC_WD-1:0]   out_imm
);
    import fe_pkg::*;

    logic               ds_valid;
    logic               ds_ready_go;
    logic [PC_WD-1:0]   ds_pc;
    logic [INST_WD-1:0] ds_inst;
    rv_opcode_e         opcode;
    op_class_e          ds_op;
    logic [PC_WD-1:0]   ds_imm;

    // Immediate candidates
    logic [PC_WD-1:0]   imm_i;
    logic [PC_WD-1:0]   imm_s;
    logic [PC_WD-1:0]   imm_b;
    logic [PC_WD-1:0]   imm_u;
    logic [PC_WD-1:0]   imm_j;

    // ------------------------------
    // ID valid and pipeline regs
    // ------------------------------
    // Decode is single cycle
    assign ds_ready_go = 1'b1;
    assign ds_allowin  = !ds_valid || (ds_ready_go && out_allowin);

    always_ff @(posedge clk) begin
        if (reset) begin
            ds_valid <= 1'b0;
        end else if (ds_allowin) begin
            ds_valid <= fs_to_ds_valid;
        end
    end

    // Payload, loaded on transfer only
    always_ff @(posedge clk) begin
        if (fs_to_ds_valid && ds_allowin) begin
            ds_pc   <= fs_pc;
            ds_inst <= fs_inst;
        end
    end

    // ------------------------------
    // Immediate formats
    // ------------------------------
    assign imm_i = {{20{ds_inst[31]}}, ds_inst[31:20]};
    assign imm_s = {{20{ds_inst[31]}}, ds_inst[31:25], ds_inst[11:7]};
    assign imm_b = {{19{ds_inst[31]}}, ds_inst[31], ds_inst[7],
                    ds_inst[30:25], ds_inst[11:8], 1'b0};
    assign imm_u = {ds_inst[31:12], 12'b0};
    assign imm_j = {{11{ds_inst[31]}}, ds_inst[31], ds_inst[19:12],
                    ds_inst[20], ds_inst[30:21], 1'b0};

    // ------------------------------
    // Opcode classification
    // ------------------------------
    assign opcode = rv_opcode_e'(ds_inst[6:0]);

    always_comb begin
        ds_op  = OP_OTHER;
        ds_imm = '0;
        case (opcode)
            OPC_OP_IMM: begin
                ds_op  = OP_ALU;
                ds_imm = imm_i;
            end
            // Register-register, no immediate
            OPC_OP: begin
                ds_op = OP_ALU;
            end
            OPC_LUI, OPC_AUIPC: begin
                ds_op  = OP_ALU;
                ds_imm = imm_u;
            end
            OPC_LOAD: begin
                ds_op  = OP_LOAD;
                ds_imm = imm_i;
            end
            OPC_STORE: begin
                ds_op  = OP_STORE;
                ds_imm = imm_s;
            end
            OPC_BRANCH: begin
                ds_op  = OP_BRANCH;
                ds_imm = imm_b;
            end
            OPC_JAL: begin
                ds_op  = OP_JAL;
                ds_imm = imm_j;
            end
            OPC_JALR: begin
                ds_op  = OP_JALR;
                ds_imm = imm_i;
            end
            default: begin
                ds_op  = OP_OTHER;
                ds_imm = '0;
            end
        endcase
    end

    // ------------------------------
    // JAL resolve, branch bus
    // ------------------------------
    // Level while JAL sits here, fetch samples it when it advances
    assign br_taken  = ds_valid && (ds_op == OP_JAL);
    assign br_target = ds_pc + imm_j;

    // Downstream interface
    assign out_valid = ds_valid && ds_ready_go;
    assign out_pc    = ds_pc;
    assign out_inst  = ds_inst;
    assign out_op    = ds_op;
    assign out_imm   = ds_imm;

    // Redirect only from a live decode slot
    a_br_needs_valid: assert property (@(posedge clk) disable iff (reset)
        br_taken |-> out_valid)
        else $error("br_taken without valid instruction");

    // Back-pressure keeps the offered instruction frozen
    a_out_stable: assert property (@(posedge clk) disable iff (reset)
        out_valid && !out_allowin |=> out_valid && $stable(out_pc)
            && $stable(out_inst) && $stable(out_imm))
        else $error("decode output changed under back-pressure");

endmodule

//--- hw/fe_pkg.sv
package fe_pkg;

    // ------------------------------
    // Datapath widths
    // ------------------------------
    localparam int PC_WD   = 32;
    localparam int INST_WD = 32;

    // PC held in fetch after reset
    // first request goes to RESET_PC + 4
    localparam logic [PC_WD-1:0] RESET_PC = 32'h0000_0000;

    // ------------------------------
    // Instruction RAM geometry
    // ------------------------------
    localparam int IMEM_DEPTH = 256;
    localparam int IMEM_AW    = 8;

    // Decoded instruction class handed downstream
    typedef enum logic [2:0] {
        OP_ALU,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JAL,
        OP_JALR,
        OP_OTHER
    } op_class_e;

    // RV32I major opcodes, inst[6:0]
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b000_0011,
        OPC_OP_IMM = 7'b001_0011,
        OPC_AUIPC  = 7'b001_0111,
        OPC_STORE  = 7'b010_0011,
        OPC_OP     = 7'b011_0011,
        OPC_LUI    = 7'b011_0111,
        OPC_BRANCH = 7'b110_0011,
        OPC_JALR   = 7'b110_0111,
        OPC_JAL    = 7'b110_1111
    } rv_opcode_e;

endpackage

//--- hw/fetch_stage.sv
module fetch_stage (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     run,
    input  logic                     ds_allowin,
    input  logic                     br_taken,
    input  logic [fe_pkg::PC_WD-1:0] br_target,
    output logic                     inst_en,
    output logic [fe_pkg::PC_WD-1:0] inst_addr,
    output logic                     fs_to_ds_valid,
    output logic [fe_pkg::PC_WD-1:0] fs_pc
);
    import fe_pkg::*;

    logic             fs_valid;
    logic             fs_ready_go;
    logic             fs_allowin;
    logic             to_fs_valid;
    logic [PC_WD-1:0] seq_pc;
    logic [PC_WD-1:0] nextpc;

    // ------------------------------
    // Pre-IF, next PC select
    // ------------------------------
    // New request only while running
    assign to_fs_valid = run;
    assign seq_pc      = fs_pc + 32'd4;
    // Decode redirect wins over sequential PC
    assign nextpc      = br_taken ? br_target : seq_pc;

    // ------------------------------
    // IF stage
    // ------------------------------
    // RAM never stalls, so IF is always done
    assign fs_ready_go    = 1'b1;
    assign fs_allowin     = !fs_valid || (fs_ready_go && ds_allowin);
    assign fs_to_ds_valid = fs_valid && fs_ready_go;

    always_ff @(posedge clk) begin
        if (reset) begin
            fs_valid <= 1'b0;
        end else if (fs_allowin) begin
            fs_valid <= to_fs_valid;
        end
    end

    // PC moves only on an advance, so a held JAL redirects once
    always_ff @(posedge clk) begin
        if (reset) begin
            fs_pc <= RESET_PC;
        end else if (to_fs_valid && fs_allowin) begin
            fs_pc <= nextpc;
        end
    end

    // RAM request tracks the PC update
    // inst_en low on a stall keeps RAM output stable
    assign inst_en   = to_fs_valid && fs_allowin;
    assign inst_addr = nextpc;

    // No fetch while reset is held, relies on run low from outside
    a_no_fetch_in_reset: assert property (@(posedge clk) reset |-> !inst_en)
        else $error("inst_en high during reset");

    // Branch targets from decode must keep PC word aligned
    a_pc_aligned: assert property (@(posedge clk) disable iff (reset)
        fs_pc[1:0] == 2'b00)
        else $error("fetch PC not word aligned: %h", fs_pc);

endmodule

//--- hw/inst_mem.sv
module inst_mem (
    input  logic                         clk,
    input  logic                         inst_en,
    input  logic [fe_pkg::IMEM_AW-1:0]   rd_addr,
    output logic [fe_pkg::INST_WD-1:0]   inst_rdata,
    input  logic                         load_en,
    input  logic [fe_pkg::IMEM_AW-1:0]   load_addr,
    input  logic [fe_pkg::INST_WD-1:0]   load_data
);
    import fe_pkg::*;

    // Word array, no reset on contents
    logic [INST_WD-1:0] mem [IMEM_DEPTH];

    // ------------------------------
    // Program load port
    // ------------------------------
    // One word per clock while run is low
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    // ------------------------------
    // Fetch read port
    // ------------------------------
    // Registered read, data one clock after request
    // Output holds when inst_en is low
    always_ff @(posedge clk) begin
        if (inst_en) begin
            inst_rdata <= mem[rd_addr];
        end
    end

    // Loading and fetching are phases that never overlap
    a_no_load_during_fetch: assert property (@(posedge clk)
        !(load_en && inst_en))
        else $error("load and fetch in same cycle, addr %h", load_addr);

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the front end testbench with Verilator

set -u
cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f verilog.f --top-module tb_frontend \
    -Mdir "$BUILD_DIR" -o tb_frontend
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/tb_frontend" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^TEST PASSED$" "$LOG"; then
    echo "simulation passed, log in $LOG"
    exit 0
else
    echo "simulation failed, log in $LOG"
    exit 1
fi

//--- verilog.f
hw/fe_pkg.sv
hw/fetch_stage.sv
hw/inst_mem.sv
hw/decode_stage.sv
hw/cpu_frontend.sv
dv/tb_frontend.sv
